// File: ppu_pkg.sv
// shared addresses, timing constants, types and bundles for the background LCD controller
package ppu_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [15:0] vram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  dot_t;
    typedef logic [7:0]  line_t;
    typedef logic [1:0]  color_t;

    // memory-mapped LCD registers
    localparam cpu_addr_t ADDR_LCDC = 16'hFF40;
    localparam cpu_addr_t ADDR_STAT = 16'hFF41;
    localparam cpu_addr_t ADDR_SCY  = 16'hFF42;
    localparam cpu_addr_t ADDR_SCX  = 16'hFF43;
    localparam cpu_addr_t ADDR_LY   = 16'hFF44;
    localparam cpu_addr_t ADDR_LYC  = 16'hFF45;
    localparam cpu_addr_t ADDR_BGP  = 16'hFF47;

    localparam dot_t  DOTS_PER_LINE   = 9'd456;
    localparam dot_t  SCAN_DOTS       = 9'd80;
    localparam line_t VISIBLE_LINES   = 8'd144;
    localparam line_t LINES_PER_FRAME = 8'd154;
    localparam byte_t SCREEN_WIDTH    = 8'd160;
    localparam logic [4:0] FETCH_TILES = 5'd21;  // 160 pixels plus up to 7 dropped by fine scroll

    localparam vram_addr_t MAP0_BASE          = 16'h9800;
    localparam vram_addr_t MAP1_BASE          = 16'h9C00;
    localparam vram_addr_t TILE_BASE_UNSIGNED = 16'h8000;
    localparam vram_addr_t TILE_BASE_SIGNED   = 16'h9000;

    // encoding matches the STAT mode field
    typedef enum logic [1:0] {
        H_BLANK  = 2'd0,
        V_BLANK  = 2'd1,
        OAM_SCAN = 2'd2,
        DRAW     = 2'd3
    } ppu_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        MAP_READ,
        ROW_LO,
        ROW_HI,
        HOLD
    } fetch_state_t;

    typedef struct packed {
        cpu_addr_t addr;
        logic      wr;
        logic      rd;
        byte_t     wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic  lcd_on;    // LCDC bit 7
        logic  bg_on;     // LCDC bit 0
        logic  map_sel;   // LCDC bit 3
        logic  tile_sel;  // LCDC bit 4, set selects unsigned tile numbers
        byte_t scx;
        byte_t scy;
        byte_t bgp;
        line_t lyc;
        logic  int_lyc;
        logic  int_m2;
        logic  int_m1;
        logic  int_m0;
    } lcd_cfg_t;

    typedef struct packed {
        logic   valid;
        color_t color;
    } pixel_t;

endpackage

// File: ppu_regs.sv
// LCD register file, decodes CPU writes and returns registered read data including live STAT/LY
module ppu_regs import ppu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  bus,
    input  ppu_mode_t mode,
    input  line_t     ly,
    input  logic      coincidence,
    output byte_t     rdata,
    output lcd_cfg_t  cfg
);

    byte_t       lcdc;
    logic [3:0]  stat_en;  // STAT bits 6..3
    byte_t       scy;
    byte_t       scx;
    line_t       lyc;
    byte_t       bgp;
    byte_t       rd_mux;

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= '0;
            stat_en <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= '0;
        end else if (bus.wr) begin
            case (bus.addr)
                ADDR_LCDC: lcdc    <= bus.wdata;
                ADDR_STAT: stat_en <= bus.wdata[6:3];  // mode and coincidence bits are read only
                ADDR_SCY:  scy     <= bus.wdata;
                ADDR_SCX:  scx     <= bus.wdata;
                ADDR_LYC:  lyc     <= bus.wdata;
                ADDR_BGP:  bgp     <= bus.wdata;
                default: ;                            // LY and unmapped writes dropped
            endcase
        end
    end

    always_comb begin
        case (bus.addr)
            ADDR_LCDC: rd_mux = lcdc;
            ADDR_STAT: rd_mux = {1'b1, stat_en, coincidence, mode};
            ADDR_SCY:  rd_mux = scy;
            ADDR_SCX:  rd_mux = scx;
            ADDR_LY:   rd_mux = ly;
            ADDR_LYC:  rd_mux = lyc;
            ADDR_BGP:  rd_mux = bgp;
            default:   rd_mux = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.rd) begin
            rdata <= rd_mux;  // valid the cycle after rd
        end
    end

    // bits 1, 2, 5 and 6 of LCDC only read back
    always_comb begin
        cfg.lcd_on   = lcdc[7];
        cfg.bg_on    = lcdc[0];
        cfg.map_sel  = lcdc[3];
        cfg.tile_sel = lcdc[4];
        cfg.scx      = scx;
        cfg.scy      = scy;
        cfg.bgp      = bgp;
        cfg.lyc      = lyc;
        cfg.int_lyc  = stat_en[3];
        cfg.int_m2   = stat_en[2];
        cfg.int_m1   = stat_en[1];
        cfg.int_m0   = stat_en[0];
    end

endmodule

// File: ppu_timing.sv
// dot/line counters and mode sequencer, produces line_start, LYC coincidence and interrupt levels
module ppu_timing import ppu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lcd_cfg_t  cfg,
    input  logic      line_done,
    output ppu_mode_t mode,
    output line_t     ly,
    output logic      coincidence,
    output logic      line_start,
    output logic      irq_vblank,
    output logic      irq_stat
);

    dot_t  dot;
    line_t next_ly;

    assign next_ly = ly + 8'd1;

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_on) begin
            dot        <= '0;
            ly         <= '0;
            mode       <= OAM_SCAN;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (dot == DOTS_PER_LINE - 9'd1) begin
                dot <= '0;
                if (ly == LINES_PER_FRAME - 8'd1) begin
                    ly   <= '0;
                    mode <= OAM_SCAN;  // new frame
                end else begin
                    ly   <= next_ly;
                    mode <= (next_ly >= VISIBLE_LINES) ? V_BLANK : OAM_SCAN;
                end
            end else begin
                dot <= dot + 9'd1;
                case (mode)
                    OAM_SCAN: begin
                        if (dot == SCAN_DOTS - 9'd1) begin
                            mode       <= DRAW;
                            line_start <= 1'b1;  // high on the first DRAW dot
                        end
                    end
                    DRAW: begin
                        if (line_done) begin
                            mode <= H_BLANK;
                        end
                    end
                    default: ;  // H_BLANK and V_BLANK run to the end of the line
                endcase
            end
        end
    end

    assign coincidence = (ly == cfg.lyc);

    // both interrupts are levels and stay quiet while the display is off
    always_comb begin
        irq_vblank = cfg.lcd_on && (mode == V_BLANK);
        irq_stat   = cfg.lcd_on && ((cfg.int_lyc && coincidence) ||
                                    (cfg.int_m0 && mode == H_BLANK) ||
                                    (cfg.int_m1 && mode == V_BLANK) ||
                                    (cfg.int_m2 && mode == OAM_SCAN));
    end

endmodule

// File: ppu_bg_fetch.sv
// background fetcher, walks the tile map for one line and hands finished tile rows to the shifter
module ppu_bg_fetch import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lcd_cfg_t   cfg,
    input  line_t      ly,
    input  logic       line_start,
    input  logic       row_take,
    input  byte_t      vram_data,
    output logic       vram_rd,
    output vram_addr_t vram_addr,
    output byte_t      row_lo,
    output byte_t      row_hi,
    output logic       row_ready
);

    fetch_state_t state;
    logic [4:0]   col;       // tile column in the 32-wide map
    logic [4:0]   tile_cnt;  // tiles handed over this line
    logic         hi_wait;   // high byte still on its way from VRAM
    byte_t        tile_num;
    byte_t        lo_q;
    byte_t        hi_q;
    line_t        y_sum;
    vram_addr_t   map_addr;

    // row address of a tile, fy selects the pixel row inside it
    function automatic vram_addr_t tile_addr(byte_t tile, logic [2:0] fy, logic unsigned_mode);
        vram_addr_t base;
        vram_addr_t offs;
        if (unsigned_mode) begin
            base = TILE_BASE_UNSIGNED;
            offs = {4'b0, tile, 4'b0};
        end else begin
            base = TILE_BASE_SIGNED;
            offs = {{4{tile[7]}}, tile, 4'b0};  // -128..127 around 9000
        end
        return base + offs + {12'b0, fy, 1'b0};
    endfunction

    assign y_sum    = ly + cfg.scy;  // wraps at 256
    assign map_addr = (cfg.map_sel ? MAP1_BASE : MAP0_BASE) + {6'b0, y_sum[7:3], col};

    // data comes back one cycle after each strobe
    always_comb begin
        vram_rd   = 1'b0;
        vram_addr = '0;
        case (state)
            MAP_READ: begin
                vram_rd   = 1'b1;
                vram_addr = map_addr;
            end
            ROW_LO: begin
                vram_rd   = 1'b1;
                vram_addr = tile_addr(vram_data, y_sum[2:0], cfg.tile_sel);  // map byte arriving now
            end
            ROW_HI: begin
                vram_rd   = 1'b1;
                vram_addr = tile_addr(tile_num, y_sum[2:0], cfg.tile_sel) + 16'd1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_on) begin
            state    <= IDLE;
            col      <= '0;
            tile_cnt <= '0;
            hi_wait  <= 1'b0;
        end else if (line_start) begin
            state    <= MAP_READ;
            col      <= cfg.scx[7:3];
            tile_cnt <= '0;
            hi_wait  <= 1'b0;
        end else begin
            case (state)
                MAP_READ: state <= ROW_LO;
                ROW_LO: begin
                    tile_num <= vram_data;
                    state    <= ROW_HI;
                end
                ROW_HI: begin
                    lo_q    <= cfg.bg_on ? vram_data : 8'h00;
                    hi_wait <= 1'b1;
                    state   <= HOLD;
                end
                HOLD: begin
                    if (hi_wait) begin
                        hi_q    <= cfg.bg_on ? vram_data : 8'h00;
                        hi_wait <= 1'b0;
                    end else if (row_take) begin
                        col      <= col + 5'd1;
                        tile_cnt <= tile_cnt + 5'd1;
                        state    <= (tile_cnt == FETCH_TILES - 5'd1) ? IDLE : MAP_READ;
                    end
                end
                default: ;  // IDLE waits for the next line
            endcase
        end
    end

    assign row_ready = (state == HOLD) && !hi_wait;
    assign row_lo    = lo_q;
    assign row_hi    = hi_q;

endmodule

// File: ppu_pixel_shift.sv
// two-plane pixel shifter, drops fine-scroll pixels, maps through BGP and counts out one line
module ppu_pixel_shift import ppu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  lcd_cfg_t cfg,
    input  logic     line_start,
    input  byte_t    row_lo,
    input  byte_t    row_hi,
    input  logic     row_ready,
    output logic     row_take,
    output pixel_t   pixel,
    output logic     line_done
);

    logic       active;
    logic [3:0] cnt;       // pixels left in the shifter
    logic [2:0] discard;
    byte_t      px_count;
    byte_t      sh_lo;
    byte_t      sh_hi;
    logic       have_px;
    color_t     raw;

    assign have_px  = active && (cnt != 4'd0);
    assign raw      = {sh_hi[7], sh_lo[7]};
    assign row_take = active && row_ready && (cnt <= 4'd1);  // refill as the last pixel leaves

    always_comb begin
        pixel.valid = have_px && (discard == 3'd0);
        pixel.color = cfg.bgp[{raw, 1'b0} +: 2];
        line_done   = pixel.valid && (px_count == SCREEN_WIDTH - 8'd1);
    end

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcd_on) begin
            active   <= 1'b0;
            cnt      <= '0;
            discard  <= '0;
            px_count <= '0;
        end else if (line_start) begin
            active   <= 1'b1;
            cnt      <= '0;
            discard  <= cfg.scx[2:0];
            px_count <= '0;
        end else begin
            if (line_done) begin
                active <= 1'b0;
            end
            if (have_px) begin
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;
                end else begin
                    px_count <= px_count + 8'd1;
                end
            end
            if (row_take) begin
                sh_lo <= row_lo;
                sh_hi <= row_hi;
                cnt   <= 4'd8;
            end else if (have_px) begin
                sh_lo <= {sh_lo[6:0], 1'b0};  // MSB is the leftmost pixel
                sh_hi <= {sh_hi[6:0], 1'b0};
                cnt   <= cnt - 4'd1;
            end
        end
    end

endmodule

// File: ppu_top.sv
// LCD controller top, connects register file, timing, fetcher and shifter to CPU, VRAM and pixel ports
module ppu_top import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    output byte_t      rdata,
    output logic       vram_rd,
    output vram_addr_t vram_addr,
    input  byte_t      vram_data,
    output pixel_t     pixel,
    output logic       irq_vblank,
    output logic       irq_stat
);

    lcd_cfg_t  cfg;
    ppu_mode_t mode;
    line_t     ly;
    logic      coincidence;
    logic      line_start;
    logic      line_done;
    byte_t     row_lo;
    byte_t     row_hi;
    logic      row_ready;
    logic      row_take;

    ppu_regs i_ppu_regs (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .mode        (mode),
        .ly          (ly),
        .coincidence (coincidence),
        .rdata       (rdata),
        .cfg         (cfg)
    );

    ppu_timing i_ppu_timing (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .line_done   (line_done),
        .mode        (mode),
        .ly          (ly),
        .coincidence (coincidence),
        .line_start  (line_start),
        .irq_vblank  (irq_vblank),
        .irq_stat    (irq_stat)
    );

    ppu_bg_fetch i_ppu_bg_fetch (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .ly         (ly),
        .line_start (line_start),
        .row_take   (row_take),
        .vram_data  (vram_data),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .row_lo     (row_lo),
        .row_hi     (row_hi),
        .row_ready  (row_ready)
    );

    ppu_pixel_shift i_ppu_pixel_shift (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_start (line_start),
        .row_lo     (row_lo),
        .row_hi     (row_hi),
        .row_ready  (row_ready),
        .row_take   (row_take),
        .pixel      (pixel),
        .line_done  (line_done)
    );

endmodule

// File: ppu_checker.sv
// testbench monitor that mirrors registers and line timing from the CPU bus and checks reads, pixels and irqs
module ppu_checker import ppu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cpu_bus_t     bus,
    input  byte_t        rdata,
    input  logic         vram_rd,
    input  pixel_t       pixel,
    input  logic         irq_vblank,
    input  logic         irq_stat,
    input  logic [255:0] test_name,
    input  byte_t        exp_data,
    input  logic         test_done,
    input  logic         timeout,
    output int           n_tests,
    output int           n_failed,
    output int           n_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    byte_t lcdc;
    byte_t stat_en;
    byte_t scy;
    byte_t scx;
    byte_t lyc;
    byte_t bgp;
    int    dot_m;        // model dot on the same edge as the DUT counter
    int    ly_m;
    int    x_m;          // pixels seen on the current line
    int    test_errs;
    logic  rd_seen;
    byte_t rd_exp;
    logic  exp_vb;
    logic  exp_st;

    // background shade at screen column px of the current model line
    function automatic color_t predict(int px);
        int    bx;
        int    by;
        int    map_a;
        int    tile_a;
        int    bit_n;
        byte_t tile;
        byte_t lo;
        byte_t hi;
        logic [1:0] idx;
        bx = (px + int'(scx)) % 256;
        by = (ly_m + int'(scy)) % 256;
        map_a = (lcdc[3] ? 'h9C00 : 'h9800) + (by / 8) * 32 + bx / 8;
        tile = tb_ppu.vram[map_a % 16384];
        if (lcdc[4]) tile_a = 'h8000 + int'(tile) * 16;
        else tile_a = 'h9000 + int'($signed(tile)) * 16;  // tile number -128..127
        tile_a = tile_a + (by % 8) * 2;
        lo = tb_ppu.vram[tile_a % 16384];
        hi = tb_ppu.vram[(tile_a + 1) % 16384];
        bit_n = 7 - bx % 8;
        idx = lcdc[0] ? {hi[bit_n], lo[bit_n]} : 2'd0;
        return bgp[2 * idx +: 2];
    endfunction

    // prints the first few errors of a test and counts all of them
    task automatic report(input string msg);
        if (test_errs < 4) $display("%s", msg);
        test_errs++;
        n_errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            {lcdc, stat_en, scy, scx, lyc, bgp} = '0;
            dot_m = 0;
            ly_m = 0;
            rd_seen = 1'b0;
        end else begin
            if (!lcdc[7]) begin
                dot_m = 0;
                ly_m = 0;
            end else if (dot_m == 455) begin
                dot_m = 0;
                ly_m = (ly_m == 153) ? 0 : ly_m + 1;
            end else begin
                dot_m++;
            end
            if (bus.wr) begin
                case (bus.addr)
                    ADDR_LCDC: lcdc = bus.wdata;
                    ADDR_STAT: stat_en = bus.wdata & 8'h78;
                    ADDR_SCY:  scy = bus.wdata;
                    ADDR_SCX:  scx = bus.wdata;
                    ADDR_LYC:  lyc = bus.wdata;
                    ADDR_BGP:  bgp = bus.wdata;
                    default: ;
                endcase
            end
            rd_seen = bus.rd;
            rd_exp = exp_data;
        end
    end

    initial begin
        n_tests = 0;
        n_failed = 0;
        n_errors = 0;
        test_errs = 0;
        x_m = 0;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (rd_seen && rdata !== rd_exp)
                report($sformatf("mismatch %0s read expected %h actual %h",
                    test_name, rd_exp, rdata));
            if (vram_rd && (!lcdc[7] || ly_m >= 144))
                report($sformatf("VRAM read while the display is off or in V-blank in %0s",
                    test_name));
            if (pixel.valid) begin
                if (!lcdc[7] || ly_m >= 144 || x_m >= 160) begin
                    report($sformatf("pixel valid outside the visible area in %0s", test_name));
                end else begin
                    if (pixel.color !== predict(x_m))
                        report($sformatf("mismatch %0s pixel %0d,%0d expected %h actual %h",
                            test_name, x_m, ly_m, predict(x_m), pixel.color));
                    x_m++;
                end
            end
            if (lcdc[7] && dot_m == 455 && ly_m < 144 && x_m != 160)
                report($sformatf("mismatch %0s pixels on line %0d expected 160 actual %0d",
                    test_name, ly_m, x_m));
            if (dot_m == 455 || !lcdc[7]) x_m = 0;
            exp_vb = lcdc[7] && ly_m >= 144;
            if (irq_vblank !== exp_vb)
                report($sformatf("mismatch %0s irq_vblank expected %b actual %b",
                    test_name, exp_vb, irq_vblank));
            // irq_stat is predicted only without the mode 0 and 2 enables as the draw length varies
            if (!stat_en[5] && !stat_en[3]) begin
                exp_st = lcdc[7] && ((stat_en[6] && ly_m == int'(lyc)) || (stat_en[4] && ly_m >= 144));
                if (irq_stat !== exp_st)
                    report($sformatf("mismatch %0s irq_stat expected %b actual %b",
                        test_name, exp_st, irq_stat));
            end
            if (timeout) begin
                test_errs++;
                n_errors++;
            end
            if (test_done) begin
                n_tests++;
                if (test_errs == 0) begin
                    $display("ok    %0s", test_name);
                end else begin
                    $display("fail  %0s with %0d errors", test_name, test_errs);
                    n_failed++;
                end
                test_errs = 0;
            end
        end
    end

endmodule

// File: tb_ppu.sv
// testbench top, clocks the LCD controller, models VRAM and runs the commands of ppu_stimulus.txt
module tb_ppu import ppu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic         clk;
    logic         rst;
    cpu_bus_t     bus;
    byte_t        rdata;
    logic         vram_rd;
    vram_addr_t   vram_addr;
    byte_t        vram_data;
    pixel_t       pixel;
    logic         irq_vblank;
    logic         irq_stat;
    logic [7:0]   vram [0:16383];
    logic [255:0] test_name;
    byte_t        exp_data;
    logic         test_done;
    logic         timeout;
    int           n_tests;
    int           n_failed;
    int           n_errors;

    ppu_top i_ppu_top (
        .clk (clk), .rst (rst), .bus (bus), .rdata (rdata),
        .vram_rd (vram_rd), .vram_addr (vram_addr), .vram_data (vram_data),
        .pixel (pixel), .irq_vblank (irq_vblank), .irq_stat (irq_stat)
    );

    ppu_checker i_ppu_checker (
        .clk (clk), .rst (rst), .bus (bus), .rdata (rdata), .vram_rd (vram_rd),
        .pixel (pixel), .irq_vblank (irq_vblank), .irq_stat (irq_stat),
        .test_name (test_name), .exp_data (exp_data), .test_done (test_done),
        .timeout (timeout), .n_tests (n_tests), .n_failed (n_failed), .n_errors (n_errors)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (vram_rd) vram_data <= vram[vram_addr[13:0]];  // one cycle read latency
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic write_reg(input cpu_addr_t a, input byte_t d);
        @(posedge clk);
        bus.addr <= a;
        bus.wdata <= d;
        bus.wr <= 1'b1;
        @(posedge clk);
        bus.wr <= 1'b0;
    endtask

    task automatic read_reg(input cpu_addr_t a, input byte_t e);
        @(posedge clk);
        bus.addr <= a;
        bus.rd <= 1'b1;
        exp_data <= e;
        @(posedge clk);
        bus.rd <= 1'b0;
        @(posedge clk);
    endtask

    task automatic pulse_done();
        @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    // waits a bit more than one frame at most for irq_vblank to reach level
    task automatic wait_vblank(input logic level, output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 80000 && !ok; n++) begin
            @(negedge clk);
            ok = (irq_vblank == level);
        end
        if (!ok) begin
            $display("timeout: irq_vblank never went to %b in %0s", level, test_name);
            @(posedge clk);
            timeout <= 1'b1;
            @(posedge clk);
            timeout <= 1'b0;
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [15:0] a;
        logic [15:0] d;
        logic [31:0] seed;
        logic        ok;
        logic        lcd_on;
        logic        bad_cmd;
        clk = 1'b0;
        rst = 1'b1;
        bus = '0;
        vram_data = '0;
        test_name = '0;
        exp_data = '0;
        test_done = 1'b0;
        timeout = 1'b0;
        lcd_on = 1'b0;
        bad_cmd = 1'b0;
        seed = 32'ha50;
        for (int i = 0; i < 16384; i++) begin
            seed = xorshift(seed);
            vram[i] = seed[7:0] ^ seed[23:16] ^ i[13:6];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("ppu_stimulus.txt", "r");
        if (fd == 0) $display("stimulus file ppu_stimulus.txt could not be opened");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                void'($sscanf(line, "%c %s %h %h", cmd, test_name, a, d));
                case (cmd)
                    "W": begin
                        write_reg(a, d[7:0]);
                        if (a == ADDR_LCDC) lcd_on = d[7];
                    end
                    "R": begin
                        read_reg(a, d[7:0]);
                        pulse_done();
                    end
                    "F": begin
                        ok = 1'b1;
                        for (int f = 0; f < int'(d) && ok; f++) begin
                            if (lcd_on) begin
                                wait_vblank(1'b0, ok);
                                if (ok) wait_vblank(1'b1, ok);
                            end else begin
                                repeat (70224) @(posedge clk);  // only the frame length passes
                            end
                        end
                        pulse_done();
                    end
                    "B": begin
                        wait_vblank(1'b1, ok);
                        pulse_done();
                    end
                    "E": begin
                        wait_vblank(1'b0, ok);
                        pulse_done();
                    end
                    default: begin
                        $display("unknown stimulus command %s", cmd);
                        bad_cmd = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        repeat (2) @(posedge clk);
        $display("tests %0d  failed %0d  errors %0d", n_tests, n_failed, n_errors);
        if (fd != 0 && !bad_cmd && n_tests > 0 && n_failed == 0 && n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: ppu_stimulus.txt
# cmd name addr data, hex fields: W write, R read and compare, F run data frames
# B wait for V-blank start, E wait for V-blank end (addr and data unused there)
W lcdc_off FF40 00
W scy_wr FF42 1D
R scy_rb FF42 1D
W scx_wr FF43 5B
R scx_rb FF43 5B
W lyc_wr FF45 32
R lyc_rb FF45 32
W bgp_wr FF47 E4
R bgp_rb FF47 E4
W stat_wr FF41 40
R stat_rb FF41 C2
W ly_wr FF44 77
R ly_rb FF44 00
R unmapped FF4C FF
W lcdc_on FF40 91
R lcdc_rb FF40 91
F frames_unsigned 0 2
B vblank_start 0 0
R ly_vblank FF44 90
E vblank_end 0 0
R ly_wrap FF44 00
W off_b FF40 00
W scx_b FF43 03
W scy_b FF42 F8
W on_b FF40 89
F frame_map1_signed 0 1
W off_c FF40 00
W scx_c FF43 FD
W on_c FF40 99
F frame_map1_unsigned 0 1
W off_d FF40 00
W on_d FF40 98
F frame_bg_off 0 1
W off_e FF40 00
W stat_e FF41 50
W on_e FF40 81
F frame_lyc_vblank_irq 0 1
W off_f FF40 00
R ly_off FF44 00
F frame_lcd_off 0 1

// File: sim.f
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
ppu_bg_fetch.sv
ppu_pixel_shift.sv
ppu_top.sv
ppu_checker.sv
tb_ppu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ppu
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat sim.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f sim.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
